/* files.f */
logic/display_pkg.sv
logic/sirds_pkg.sv
logic/depth_scene.sv
logic/separation_stage.sv
logic/link_stage.sv
logic/color_stage.sv
logic/sirds_top.sv
testbench/clock_gen.sv
testbench/sirds_tb.sv

/* logic/color_stage.sv */
// Color stage, random dots and the line buffer pick the gray shade of each pixel
module color_stage
	import display_pkg::*, sirds_pkg::*;
#(
	parameter int line_width = 640
)
(
	input  logic          VGA_CTRL_CLK,
	input  logic          reset,
	input  link_px_t      in_px,
	input  display_mode_t mode,
	output logic          shade_strobe,
	output logic [7:0]    shade
);

	// Shades already written on this line
	logic [7:0] line_buf [line_width];

	// Random dot source
	logic [30:0] lfsr;
	logic        lfsr_fb;
	logic [7:0]  dot;

	// Read cycle
	link_px_t   s1_px;
	logic [7:0] linked_shade;
	logic [7:0] next_shade;

	// Taps 31 and 28
	assign lfsr_fb = lfsr[30] ^ lfsr[27];

	////////////////////////////////
	// Random dot
	////////////////////////////////

	// One shift per pixel, dot keeps the last 8 bits out
	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (reset)
		begin
			lfsr <= lfsr_seed;
			dot  <= '0;
		end
		else if (in_px.valid)
		begin
			lfsr <= {lfsr[29:0], lfsr_fb};
			dot  <= {dot[6:0], lfsr[30]};
		end
	end

	////////////////////////////////
	// Read, select and write
	////////////////////////////////

	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (reset)
			s1_px.valid <= 1'b0;
		else if (in_px.valid)
			s1_px <= in_px;
		else
			s1_px.valid <= 1'b0;
	end

	// Linked pixel sits at least 8 back, so it is already written
	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (in_px.valid)
			linked_shade <= line_buf[in_px.link];
		if (s1_px.valid)
			line_buf[s1_px.x] <= next_shade;
	end

	always_comb
	begin
		case (mode)
			// Unlinked pixels start a fresh random dot
			mode_stereo: next_shade = (s1_px.link == s1_px.x) ? dot : linked_shade;
			mode_depth:  next_shade = s1_px.depth;
			mode_link:   next_shade = s1_px.link[9:2];
			default:     next_shade = 8'd0;
		endcase
	end

	// Output register
	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (reset)
			shade_strobe <= 1'b0;
		else
		begin
			shade_strobe <= s1_px.valid;
			if (s1_px.valid)
				shade <= next_shade;
		end
	end

endmodule

/* logic/depth_scene.sv */
// Scene depth stage, turns each strobed pixel coordinate into a depth from the built-in scene
module depth_scene
	import display_pkg::*, sirds_pkg::*;
(
	input  logic        VGA_CTRL_CLK,
	input  logic        reset,
	input  logic        pixel_strobe,
	input  coord_t      x,
	input  coord_t      y,
	input  key_strobe_t keys,
	output scene_px_t   px
);

	logic [31:0] frame_count;
	logic [4:0]  level;

	// Scene helpers
	logic [7:0]  ramp;
	logic [16:0] seesaw_prod;
	logic [8:0]  bounce_pos;
	logic [10:0] bounce_lo;
	logic [10:0] x_ext;
	logic [7:0]  depth;

	////////////////////////////////
	// Frame and level state
	////////////////////////////////

	// One tick per frame, on the top left pixel
	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (reset)
			frame_count <= '0;
		else if (pixel_strobe && x == '0 && y == '0)
			frame_count <= frame_count + 32'd1;
	end

	// Level steps with saturation
	// Down has priority when both keys strobe together
	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (reset)
			level <= '0;
		else if (keys.level_down)
		begin
			if (level != '0)
				level <= level - 5'd1;
		end
		else if (keys.level_up)
		begin
			if (level != 5'(max_level))
				level <= level + 5'd1;
		end
	end

	////////////////////////////////
	// Scene rules
	////////////////////////////////

	always_comb
	begin
		// Seesaw tilt swings up then down with frame bit 25
		ramp = frame_count[25] ? frame_count[24:17] : 8'd255 - frame_count[24:17];
		// Half x times tilt, scaled by 1/256 below
		seesaw_prod = x[9:1] * ramp;

		// Bouncing box sweeps right, then mirrors back
		bounce_pos = frame_count[26] ? frame_count[25:17] : 9'd511 - frame_count[25:17];
		bounce_lo  = 11'(bounce_offset) + {2'b00, bounce_pos};
		x_ext      = {1'b0, x};

		// Background
		depth = 8'd0;

		if (y >= seesaw_row_lo && y < seesaw_row_hi)
		begin
			if (x < seesaw_col_hi)
				depth = 8'(seesaw_prod >> 8);
		end
		else if (y >= box_row_lo && y < box_row_hi)
		begin
			if (x >= fixed_col_lo && x < fixed_col_hi)
				depth = box_depth;
			else if (x >= adj_col_lo && x < adj_col_hi)
				depth = level_depth[level];
		end
		else if (y >= bounce_row_lo && y < bounce_row_hi)
		begin
			if (x_ext >= bounce_lo && x_ext < bounce_lo + 11'(bounce_width))
				depth = box_depth;
		end
	end

	// Stage register
	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (reset)
			px.valid <= 1'b0;
		else
		begin
			px.valid <= pixel_strobe;
			if (pixel_strobe)
			begin
				px.x     <= x;
				px.y     <= y;
				px.depth <= depth;
			end
		end
	end

endmodule

/* logic/display_pkg.sv */
// Display package with screen coordinates, display modes, key strobes and scene layout
package display_pkg;

	// Pixel coordinate on the raster
	typedef logic [9:0] coord_t;

	// What the gray output shows
	typedef enum logic [1:0] {
		mode_stereo = 2'd0,
		mode_depth  = 2'd1,
		mode_link   = 2'd2
	} display_mode_t;

	// Debounced single-cycle key presses
	typedef struct packed {
		logic level_up;
		logic level_down;
	} key_strobe_t;

	////////////////////////////////
	// Scene layout, upper bounds exclusive
	////////////////////////////////

	// Seesaw band
	localparam int seesaw_row_lo = 60;
	localparam int seesaw_row_hi = 100;
	localparam int seesaw_col_hi = 552;

	// Fixed and adjustable boxes share one row band
	localparam int box_row_lo   = 190;
	localparam int box_row_hi   = 290;
	localparam int fixed_col_lo = 170;
	localparam int fixed_col_hi = 270;
	localparam int adj_col_lo   = 370;
	localparam int adj_col_hi   = 470;

	// Bouncing box
	localparam int bounce_row_lo = 380;
	localparam int bounce_row_hi = 420;
	localparam int bounce_width  = 40;
	localparam int bounce_offset = 44;

	// Height of the fixed and bouncing boxes
	localparam logic [7:0] box_depth = 8'd144;

	// Top step of the adjustable box
	localparam int max_level = 27;

endpackage

/* logic/link_stage.sv */
// Link stage, ping-pong link buffers that resolve which pixel each pixel copies
module link_stage
	import display_pkg::*, sirds_pkg::*;
#(
	parameter int line_width = 640
)
(
	input  logic     VGA_CTRL_CLK,
	input  logic     reset,
	input  pair_px_t in_px,
	output link_px_t out_px
);

	// Odd lines prime link_a and work in link_b, even lines swap
	coord_t link_a [line_width];
	coord_t link_b [line_width];

	logic   in_line;
	coord_t left_idx;
	coord_t right_idx;
	coord_t link;

	always_comb
	begin
		// Both partners must land on the visible line
		in_line   = (in_px.left >= 0) && (in_px.right < line_width);
		left_idx  = in_px.left[9:0];
		right_idx = in_px.right[9:0];

		// Pixel that is its own right partner takes the left one directly
		if (in_line && in_px.x == right_idx)
			link = left_idx;
		else if (in_px.y[0])
			link = link_b[in_px.x];
		else
			link = link_a[in_px.x];
	end

	////////////////////////////////
	// Buffer updates
	////////////////////////////////

	// Idle buffer gets identity entries for the next line
	// Active buffer ties the right partner to the left one
	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (in_px.valid)
		begin
			if (in_px.y[0])
			begin
				link_a[in_px.x] <= in_px.x;
				if (in_line)
					link_b[right_idx] <= left_idx;
			end
			else
			begin
				link_b[in_px.x] <= in_px.x;
				if (in_line)
					link_a[right_idx] <= left_idx;
			end
		end
	end

	// Stage register
	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (reset)
			out_px.valid <= 1'b0;
		else
		begin
			out_px.valid <= in_px.valid;
			if (in_px.valid)
			begin
				out_px.x     <= in_px.x;
				out_px.y     <= in_px.y;
				out_px.depth <= in_px.depth;
				out_px.link  <= link;
			end
		end
	end

endmodule

/* logic/separation_stage.sv */
// Separation stage that looks up the eye separation and places the left and right partners
module separation_stage
	import sirds_pkg::*;
(
	input  logic      VGA_CTRL_CLK,
	input  logic      reset,
	input  scene_px_t in_px,
	output pair_px_t  out_px
);

	// First cycle holds the pixel and its separation
	scene_px_t s1_px;
	logic [7:0] sep;

	// Partner positions may run off either end
	logic signed [10:0] left_pos;
	logic signed [10:0] right_pos;

	////////////////////////////////
	// Table read
	////////////////////////////////

	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (reset)
			s1_px.valid <= 1'b0;
		else if (in_px.valid)
			s1_px <= in_px;
		else
			s1_px.valid <= 1'b0;
	end

	// Separation for the held pixel
	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (in_px.valid)
			sep <= sep_table[in_px.depth];
	end

	////////////////////////////////
	// Partner placement
	////////////////////////////////

	// Odd separation puts the extra pixel on the right
	always_comb
	begin
		left_pos  = {1'b0, s1_px.x} - {4'b0000, sep[7:1]};
		right_pos = {1'b0, s1_px.x} + {4'b0000, sep[7:1]} + {10'd0, sep[0]};
	end

	always_ff @(posedge VGA_CTRL_CLK)
	begin
		if (reset)
			out_px.valid <= 1'b0;
		else
		begin
			out_px.valid <= s1_px.valid;
			if (s1_px.valid)
			begin
				out_px.x     <= s1_px.x;
				out_px.y     <= s1_px.y;
				out_px.depth <= s1_px.depth;
				out_px.left  <= left_pos;
				out_px.right <= right_pos;
			end
		end
	end

endmodule

/* logic/sirds_pkg.sv */
// Stereogram pipeline package with stage payloads and the depth lookup tables
package sirds_pkg;

	// Out of depth_scene
	typedef struct packed {
		logic                valid;
		display_pkg::coord_t x;
		display_pkg::coord_t y;
		logic [7:0]          depth;
	} scene_px_t;

	// Out of separation_stage, partners may fall off the line
	typedef struct packed {
		logic                valid;
		display_pkg::coord_t x;
		display_pkg::coord_t y;
		logic [7:0]          depth;
		logic signed [10:0]  left;
		logic signed [10:0]  right;
	} pair_px_t;

	// Out of link_stage
	typedef struct packed {
		logic                valid;
		display_pkg::coord_t x;
		display_pkg::coord_t y;
		logic [7:0]          depth;
		display_pkg::coord_t link;
	} link_px_t;

	////////////////////////////////
	// Depth to eye separation
	////////////////////////////////

	localparam int sep_max = 80;
	localparam int sep_min = 8;

	typedef logic [7:0] sep_table_t [256];

	// Linear falloff, near objects get the narrower separation
	function automatic sep_table_t build_sep_table();
		sep_table_t t;
		int s;
		for (int d = 0; d < 256; d++)
		begin
			s = sep_max - (d * 5) / 32;
			t[d] = (s < sep_min) ? 8'(sep_min) : 8'(s);
		end
		return t;
	endfunction

	localparam sep_table_t sep_table = build_sep_table();

	// Adjustable box height per level step
	localparam logic [7:0] level_depth [display_pkg::max_level + 1] = '{
		8'd0,   8'd9,   8'd23,  8'd36,  8'd48,  8'd60,  8'd72,
		8'd83,  8'd94,  8'd105, 8'd115, 8'd125, 8'd135, 8'd144,
		8'd153, 8'd162, 8'd170, 8'd179, 8'd187, 8'd194, 8'd202,
		8'd209, 8'd217, 8'd224, 8'd231, 8'd237, 8'd244, 8'd250
	};

	// Random dot generator start state, any nonzero value
	localparam logic [30:0] lfsr_seed = 31'h5A3C_96E1;

endpackage

/* logic/sirds_top.sv */
// Stereogram pipeline top, chains scene, separation, link and color stages
module sirds_top
	import display_pkg::*, sirds_pkg::*;
#(
	parameter int line_width = 640
)
(
	input  logic          VGA_CTRL_CLK,
	input  logic          reset,
	input  logic          pixel_strobe,
	input  coord_t        x,
	input  coord_t        y,
	input  display_mode_t mode,
	input  key_strobe_t   keys,
	output logic          shade_strobe,
	output logic [7:0]    shade
);

	// Stage payloads
	scene_px_t scene_px;
	pair_px_t  pair_px;
	link_px_t  link_px;

	// 1 cycle
	depth_scene u_scene (
		.VGA_CTRL_CLK (VGA_CTRL_CLK),
		.reset        (reset),
		.pixel_strobe (pixel_strobe),
		.x            (x),
		.y            (y),
		.keys         (keys),
		.px           (scene_px)
	);

	// 2 cycles
	separation_stage u_sep (
		.VGA_CTRL_CLK (VGA_CTRL_CLK),
		.reset        (reset),
		.in_px        (scene_px),
		.out_px       (pair_px)
	);

	// 1 cycle
	link_stage #(
		.line_width (line_width)
	) u_link (
		.VGA_CTRL_CLK (VGA_CTRL_CLK),
		.reset        (reset),
		.in_px        (pair_px),
		.out_px       (link_px)
	);

	// 2 cycles
	color_stage #(
		.line_width (line_width)
	) u_color (
		.VGA_CTRL_CLK (VGA_CTRL_CLK),
		.reset        (reset),
		.in_px        (link_px),
		.mode         (mode),
		.shade_strobe (shade_strobe),
		.shade        (shade)
	);

endmodule

/* testbench/clock_gen.sv */
// Testbench clock and power-on reset source, 20-unit period and 3 cycles of reset
module clock_gen
(
	output logic VGA_CTRL_CLK,
	output logic reset
);

	// Reset held over three rising edges, released on a falling edge
	initial
	begin
		VGA_CTRL_CLK = 1'b0;
		reset        = 1'b1;
		repeat (3) @(posedge VGA_CTRL_CLK);
		@(negedge VGA_CTRL_CLK);
		reset = 1'b0;
	end

	always #10 VGA_CTRL_CLK = ~VGA_CTRL_CLK;

endmodule

/* testbench/sirds_input.txt */
# name mode(0 stereo, 1 depth, 2 link) ups downs both start_line line_count
# then three depth samples as x y depth, each on a scanned line
depth_seesaw   1  0  0 0  59 3  100  60  49  400  61 199  600  61   0
depth_boxes    1  0  0 0 189 2  170 190 144  270 190   0  400 190   0
depth_bounce   1  0  0 0 379 2  555 380 144  594 380 144  595 380   0
level_up       1  5  0 0 200 1  370 200  60  469 200  60  470 200   0
level_top      1 30  0 0 210 1  400 210 250  200 210 144  369 210   0
level_both     1  2  3 2 220 1  370 220 217  469 220 217  100 220   0
level_zero     1  0 40 0 230 1  370 230   0  170 230 144  500 230   0
link_rows      2  0  0 0 250 2    0 250   0  200 251 144  639 250   0
link_seesaw    2  0  0 0  70 2  200  70  99   20  71   9  560  70   0
stereo_seesaw  0  0  0 0  80 3  300  80 149    8  81   3  552  82   0
stereo_boxes   0  3  0 0 195 3  370 196  36  269 197 144  470 195   0
stereo_bounce  0  0  0 0 399 2  560 400 144  554 399   0   10 400   0

/* testbench/sirds_tb.sv */
// Stereogram pipeline testbench, scans file-driven tests and checks shades against a model
module sirds_tb
	import display_pkg::*, sirds_pkg::*;
();

	localparam int line_width = 640;

	// One test row of the stimulus file
	typedef struct packed {
		int mode;
		int ups;
		int downs;
		int both;
		int start;
		int count;
	} test_row_t;

	typedef struct packed {
		int x;
		int y;
		int d;
	} sample_t;

	// Strobed pixel waiting for its shade
	typedef struct packed {
		int         start;
		int         test;
		logic [7:0] shade;
	} pending_t;

	logic          VGA_CTRL_CLK;
	logic          reset;
	logic          pixel_strobe;
	coord_t        x;
	coord_t        y;
	display_mode_t mode;
	key_strobe_t   keys;
	logic          shade_strobe;
	logic [7:0]    shade;

	string     names[$];
	test_row_t rows[$];
	sample_t   samples[$];
	pending_t  expect_q[$];

	int cycle = 0;
	int watch_cycles = 0;
	int checks = 0;
	int mismatches = 0;
	int other_errors = 0;
	int samples_hit = 0;
	logic [31:0] rng = 32'h5602;

	// Model state
	logic [31:0] m_frame = '0;
	int          m_level = 0;
	logic [30:0] m_lfsr = lfsr_seed;
	logic [7:0]  m_dot = '0;
	int          model_link_a [line_width];
	int          model_link_b [line_width];
	logic [7:0]  m_line [line_width];

	clock_gen u_clk (
		.VGA_CTRL_CLK (VGA_CTRL_CLK),
		.reset        (reset)
	);

	sirds_top #(
		.line_width (line_width)
	) dut (
		.VGA_CTRL_CLK (VGA_CTRL_CLK),
		.reset        (reset),
		.pixel_strobe (pixel_strobe),
		.x            (x),
		.y            (y),
		.mode         (mode),
		.keys         (keys),
		.shade_strobe (shade_strobe),
		.shade        (shade)
	);

	always @(posedge VGA_CTRL_CLK)
		cycle <= cycle + 1;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic compare_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s %s expected %0d actual %0d", test, what, expected, actual);
			mismatches++;
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic int scene_depth(input int px, input int py);
		int ramp;
		int lo;
		// Tilt and bounce both come from the frame count
		ramp = m_frame[25] ? int'(m_frame[24:17]) : 255 - int'(m_frame[24:17]);
		lo   = bounce_offset + (m_frame[26] ? int'(m_frame[25:17]) : 511 - int'(m_frame[25:17]));
		if (py >= seesaw_row_lo && py < seesaw_row_hi)
			return (px < seesaw_col_hi) ? ((px / 2) * ramp / 256) % 256 : 0;
		else if (py >= box_row_lo && py < box_row_hi)
		begin
			if (px >= fixed_col_lo && px < fixed_col_hi)
				return int'(box_depth);
			else if (px >= adj_col_lo && px < adj_col_hi)
				return int'(level_depth[m_level]);
			return 0;
		end
		else if (py >= bounce_row_lo && py < bounce_row_hi)
			return (px >= lo && px < lo + bounce_width) ? int'(box_depth) : 0;
		return 0;
	endfunction

	// Straight line from 80 at depth 0 toward 40 at depth 256, floor of 8
	function automatic int separation(input int depth);
		int s;
		s = 80 - (depth * 5) / 32;
		return (s < 8) ? 8 : s;
	endfunction

	task automatic model_pixel(input int px, input int py, input int t, output logic [7:0] exp);
		int   depth;
		int   sep;
		int   left;
		int   right;
		int   link;
		logic in_line;
		depth = scene_depth(px, py);
		if (px == 0 && py == 0)
			m_frame = m_frame + 32'd1;
		for (int k = 3 * t; k < 3 * t + 3; k++)
		begin
			if (samples[k].x == px && samples[k].y == py)
			begin
				compare_value(names[t], "depth sample", samples[k].d, depth);
				samples_hit++;
			end
		end
		sep     = separation(depth);
		left    = px - sep / 2;
		right   = px + sep / 2 + sep % 2;
		in_line = (left >= 0) && (right < line_width);
		if (in_line && px == right)
			link = left;
		else
			link = (py % 2 == 1) ? model_link_b[px] : model_link_a[px];
		// Odd lines prime buffer a and work in b
		if (py % 2 == 1)
		begin
			model_link_a[px] = px;
			if (in_line)
				model_link_b[right] = left;
		end
		else
		begin
			model_link_b[px] = px;
			if (in_line)
				model_link_a[right] = left;
		end
		// LFSR taps 31 and 28, one shift per pixel
		m_dot  = {m_dot[6:0], m_lfsr[30]};
		m_lfsr = {m_lfsr[29:0], m_lfsr[30] ^ m_lfsr[27]};
		if (rows[t].mode == int'(mode_depth))
			exp = 8'(depth);
		else if (rows[t].mode == int'(mode_link))
			exp = 8'(link >> 2);
		else
			exp = (link == px) ? m_dot : m_line[link];
		m_line[px] = exp;
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic idle_cycles(input int n);
		pixel_strobe = 1'b0;
		repeat (n) @(negedge VGA_CTRL_CLK);
	endtask

	// Down wins when both keys strobe together
	task automatic press_keys(input logic up, input logic down);
		keys.level_up   = up;
		keys.level_down = down;
		if (down)
			m_level = (m_level > 0) ? m_level - 1 : 0;
		else if (up)
			m_level = (m_level < max_level) ? m_level + 1 : m_level;
		@(negedge VGA_CTRL_CLK);
		keys = '0;
		@(negedge VGA_CTRL_CLK);
	endtask

	task automatic scan_lines(input int t);
		logic [7:0] exp_shade;
		for (int ln = rows[t].start; ln < rows[t].start + rows[t].count; ln++)
		begin
			for (int px = 0; px < line_width; px++)
			begin
				// Occasional idle gap, otherwise back to back
				rng = lcg_next(rng);
				if (rng[31:29] == 3'd0)
					idle_cycles(int'(rng[27:26]) + 1);
				model_pixel(px, ln, t, exp_shade);
				pixel_strobe = 1'b1;
				x            = coord_t'(px);
				y            = coord_t'(ln);
				expect_q.push_back(pending_t'{cycle, t, exp_shade});
				@(negedge VGA_CTRL_CLK);
			end
		end
		pixel_strobe = 1'b0;
	endtask

	task automatic load_tests(output logic ok);
		int    fd;
		int    n;
		int    m;
		int    u;
		int    dn;
		int    b;
		int    st;
		int    ct;
		int    v [9];
		string line;
		string name;
		ok = 1'b1;
		fd = $fopen("testbench/sirds_input.txt", "r");
		if (fd == 0)
			ok = 1'b0;
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				// Skip comments and blank lines
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
					m, u, dn, b, st, ct, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
				if (n != 16)
				begin
					$display("Malformed stimulus row: %s", line);
					ok = 1'b0;
				end
				else
				begin
					names.push_back(name);
					rows.push_back(test_row_t'{m, u, dn, b, st, ct});
					for (int k = 0; k < 9; k += 3)
						samples.push_back(sample_t'{v[k], v[k + 1], v[k + 2]});
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_tests();
		for (int t = 0; t < rows.size(); t++)
		begin
			mode = display_mode_t'(rows[t].mode[1:0]);
			repeat (rows[t].ups) press_keys(1'b1, 1'b0);
			repeat (rows[t].downs) press_keys(1'b0, 1'b1);
			repeat (rows[t].both) press_keys(1'b1, 1'b1);
			idle_cycles(1);
			scan_lines(t);
			// Drain before the next mode change
			while (expect_q.size() != 0)
				@(negedge VGA_CTRL_CLK);
		end
	endtask

	//////////////////////////////
	// Output monitor
	//////////////////////////////

	// Outputs sampled mid-cycle, each shade exactly 6 cycles after its strobe
	always @(negedge VGA_CTRL_CLK)
	begin
		if (!reset)
		begin
			if (shade_strobe === 1'b1)
			begin
				if (expect_q.size() == 0)
				begin
					$display("shade_strobe high at cycle %0d with no pixel outstanding", cycle);
					other_errors++;
				end
				else
				begin
					compare_value(names[expect_q[0].test], "latency", 6, cycle - expect_q[0].start);
					compare_value(names[expect_q[0].test], "shade", expect_q[0].shade, shade);
					void'(expect_q.pop_front());
					checks++;
				end
			end
			else if (shade_strobe !== 1'b0)
			begin
				$display("shade_strobe is unknown at cycle %0d", cycle);
				other_errors++;
			end
			else if (expect_q.size() != 0 && cycle - expect_q[0].start >= 6)
			begin
				$display("No shade_strobe for %s pixel strobed at cycle %0d",
					names[expect_q[0].test], expect_q[0].start);
				void'(expect_q.pop_front());
				other_errors++;
			end
		end
	end

	// Limit scales with the number of scheduled pixels and key cycles
	initial
	begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge VGA_CTRL_CLK);
		$display("Watchdog expired after %0d cycles, %0d shades outstanding",
			watch_cycles, expect_q.size());
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		logic ok;
		int   scheduled;
		pixel_strobe = 1'b0;
		x            = '0;
		y            = '0;
		mode         = mode_depth;
		keys         = '0;
		scheduled    = 0;
		load_tests(ok);
		if (!ok)
		begin
			$display("Stimulus file testbench/sirds_input.txt could not be read");
			$display("Testbench failed");
			$finish;
		end
		else
		begin
			foreach (rows[t])
				scheduled += rows[t].count * line_width
					+ 2 * (rows[t].ups + rows[t].downs + rows[t].both) + 1;
			watch_cycles = 10 * scheduled + 1000;
			@(negedge VGA_CTRL_CLK);
			while (reset)
				@(negedge VGA_CTRL_CLK);
			run_tests();
			if (samples_hit != samples.size())
			begin
				$display("Only %0d of %0d depth samples lie on scanned lines",
					samples_hit, samples.size());
				other_errors++;
			end
			$display("Shades checked %0d, mismatches %0d, other errors %0d",
				checks, mismatches, other_errors);
			if (mismatches == 0 && other_errors == 0 && checks > 0)
				$display("Testbench passed");
			else
				$display("Testbench failed");
			$finish;
		end
	end

endmodule
